// File: Bender.yml
package:
  name: csr_index

sources:
  - files:
      - hw/csr_engine_pkg.sv
      - hw/csr_packet_pkg.sv
      - hw/csr_sync_fifo.sv
      - hw/csr_index_configure.sv
      - hw/csr_index_generator.sv
      - hw/csr_index_control.sv
      - hw/csr_index_top.sv
  - target: simulation
    files:
      - sim/csr_index_checker.sv
      - sim/csr_index_tb.sv

// File: csr_index.f
hw/csr_engine_pkg.sv
hw/csr_packet_pkg.sv
hw/csr_sync_fifo.sv
hw/csr_index_configure.sv
hw/csr_index_generator.sv
hw/csr_index_control.sv
hw/csr_index_top.sv
sim/csr_index_checker.sv
sim/csr_index_tb.sv

// File: hw/csr_engine_pkg.sv
// ----------------------------------------------------------
// Engine constants shared across the CSR index lane.
// Holds buffer subclass codes and the index and id widths.
// ----------------------------------------------------------

package csr_engine_pkg;

    // ----------------------------------------------------------
    // Field widths
    // ----------------------------------------------------------
    // Index, end and array size fields
    localparam int INDEX_WIDTH = 32;

    // Buffer subclass code in the packet meta
    localparam int SUBCLASS_WIDTH = 2;

    // CU id and engine id fields in the packet meta
    localparam int ID_WIDTH = 4;

    // ----------------------------------------------------------
    // Buffer subclass codes
    // ----------------------------------------------------------
    // Accepted by every lane
    localparam logic [SUBCLASS_WIDTH-1:0] STRUCT_CU_SETUP = 2'd1;

    // Accepted only by the lane whose engine id matches
    localparam logic [SUBCLASS_WIDTH-1:0] STRUCT_ENGINE_SETUP = 2'd2;

endpackage : csr_engine_pkg

// File: hw/csr_index_configure.sv
// ----------------------------------------------------------
// Pops response packets, keeps CU setup and matching engine
// setup packets, and pushes clipped index configurations.
// ----------------------------------------------------------

`timescale 1ns/1ns

module csr_index_configure
    import csr_engine_pkg::*;
    import csr_packet_pkg::*;
#(
    parameter int ID_ENGINE = 3
) (
    input  logic        ap_clk,
    input  logic        areset_csr_index_generator,
    input  logic        resp_empty,
    output logic        resp_pop,
    input  csr_resp_t   resp_head,
    input  logic        cfg_full,
    output logic        cfg_push,
    output csr_config_t cfg_data,
    output logic        conf_pending
);

    csr_resp_t              hold_pkt;
    logic                   hold_valid;
    logic                   keep;
    logic [INDEX_WIDTH-1:0] end_clip;

    // One packet in flight at a time, so a free slot at pop
    // time is still free when the push lands
    assign resp_pop = !resp_empty && !cfg_full && !hold_valid && !cfg_push;

    // ----------------------------------------------------------
    // Capture stage
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= resp_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (resp_pop) begin
            hold_pkt <= resp_head;
        end
    end

    // ----------------------------------------------------------
    // Filter and clip
    // ----------------------------------------------------------
    always_comb begin
        keep = (hold_pkt.meta.subclass == STRUCT_CU_SETUP) ||
               ((hold_pkt.meta.subclass == STRUCT_ENGINE_SETUP) &&
                (hold_pkt.meta.engine_id == ID_WIDTH'(ID_ENGINE)));
        // End never runs past the array
        if (hold_pkt.field[1] > hold_pkt.field[3]) begin
            end_clip = hold_pkt.field[3];
        end else begin
            end_clip = hold_pkt.field[1];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            cfg_push <= 1'b0;
        end else begin
            cfg_push <= hold_valid && keep;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (hold_valid) begin
            cfg_data.meta        <= hold_pkt.meta;
            cfg_data.index_start <= hold_pkt.field[0];
            cfg_data.index_end   <= end_clip;
        end
    end

    // Anything queued or in flight on this side of the config FIFO
    assign conf_pending = !resp_empty || hold_valid || cfg_push;

    // Free slot seen at pop must survive to the push
    a_cfg_room : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        cfg_push |-> !cfg_full
    );

endmodule : csr_index_configure

// File: hw/csr_index_control.sv
// ----------------------------------------------------------
// Lane control. Runs the ingress handshake, pushes responses,
// and launches configurations into the index generator.
// ----------------------------------------------------------

`timescale 1ns/1ns

module csr_index_control (
    input  logic ap_clk,
    input  logic areset_csr_index_generator,
    input  logic resp_req,
    output logic resp_ack,
    input  logic resp_full,
    output logic resp_push,
    input  logic cfg_empty,
    output logic cfg_pop,
    output logic gen_start,
    input  logic gen_done,
    output logic busy,
    input  logic conf_pending
);

    typedef enum logic [1:0] {
        IN_IDLE,
        IN_PUSH,
        IN_ACK
    } in_state_t;

    in_state_t in_state;
    logic      active;

    // ----------------------------------------------------------
    // Ingress handshake
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            in_state <= IN_IDLE;
            resp_ack <= 1'b0;
        end else begin
            case (in_state)
                IN_IDLE: begin
                    // Hold off while the response FIFO is full
                    if (resp_req && !resp_full) begin
                        in_state <= IN_PUSH;
                    end
                end
                IN_PUSH: begin
                    resp_ack <= 1'b1;
                    in_state <= IN_ACK;
                end
                IN_ACK: begin
                    if (!resp_req) begin
                        resp_ack <= 1'b0;
                        in_state <= IN_IDLE;
                    end
                end
                default: begin
                    in_state <= IN_IDLE;
                end
            endcase
        end
    end

    // Single write per request, data held stable by the sender
    assign resp_push = (in_state == IN_PUSH);

    // ----------------------------------------------------------
    // Generator launch
    // ----------------------------------------------------------
    assign cfg_pop   = !cfg_empty && !active;
    assign gen_start = cfg_pop;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            active <= 1'b0;
        end else if (gen_start) begin
            active <= 1'b1;
        end else if (gen_done) begin
            active <= 1'b0;
        end
    end

    assign busy = active || !cfg_empty || conf_pending || resp_push;

    // Generator reports done only for a launch still in flight
    a_done_after_launch : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        gen_done |-> active
    );

endmodule : csr_index_control

// File: hw/csr_index_generator.sv
// ----------------------------------------------------------
// Walks one index configuration from start up to end and
// sends each index over a four-phase req/ack handshake.
// ----------------------------------------------------------

`timescale 1ns/1ns

module csr_index_generator
    import csr_engine_pkg::*;
    import csr_packet_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_csr_index_generator,
    input  logic        gen_start,
    input  csr_config_t gen_cfg,
    output logic        gen_done,
    output logic        idx_req,
    output csr_index_t  idx_data,
    input  logic        idx_ack
);

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_REQ,
        GEN_RELEASE
    } gen_state_t;

    gen_state_t             state;
    logic [INDEX_WIDTH-1:0] cur_idx;
    logic [INDEX_WIDTH-1:0] end_idx;
    csr_meta_t              cur_meta;

    // ----------------------------------------------------------
    // Handshake FSM
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            state    <= GEN_IDLE;
            idx_req  <= 1'b0;
            gen_done <= 1'b0;
        end else begin
            gen_done <= 1'b0;
            case (state)
                GEN_IDLE: begin
                    if (gen_start) begin
                        // Empty range finishes at once
                        if (gen_cfg.index_start >= gen_cfg.index_end) begin
                            gen_done <= 1'b1;
                        end else begin
                            idx_req <= 1'b1;
                            state   <= GEN_REQ;
                        end
                    end
                end
                GEN_REQ: begin
                    if (idx_ack) begin
                        idx_req <= 1'b0;
                        state   <= GEN_RELEASE;
                    end
                end
                GEN_RELEASE: begin
                    // Wait for ack low before the next index
                    if (!idx_ack) begin
                        if (cur_idx + 1'b1 >= end_idx) begin
                            gen_done <= 1'b1;
                            state    <= GEN_IDLE;
                        end else begin
                            idx_req <= 1'b1;
                            state   <= GEN_REQ;
                        end
                    end
                end
                default: begin
                    state <= GEN_IDLE;
                end
            endcase
        end
    end

    // Range registers
    always_ff @(posedge ap_clk) begin
        if (state == GEN_IDLE && gen_start) begin
            cur_idx  <= gen_cfg.index_start;
            end_idx  <= gen_cfg.index_end;
            cur_meta <= gen_cfg.meta;
        end else if (state == GEN_RELEASE && !idx_ack) begin
            cur_idx <= cur_idx + 1'b1;
        end
    end

    assign idx_data.meta  = cur_meta;
    assign idx_data.index = cur_idx;

    // Request and data hold until the consumer acks
    a_idx_hold : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        idx_req && !idx_ack |=> idx_req && $stable(idx_data)
    );

endmodule : csr_index_generator

// File: hw/csr_index_top.sv
// ----------------------------------------------------------
// CSR index lane top level. Connects control, the response
// and config FIFOs, the configure stage and the generator.
// ----------------------------------------------------------

`timescale 1ns/1ns

module csr_index_top
    import csr_packet_pkg::*;
#(
    parameter int FIFO_DEPTH = 8,
    parameter int ID_ENGINE  = 3
) (
    input  logic       ap_clk,
    input  logic       areset_csr_index_generator,
    input  logic       resp_req,
    input  csr_resp_t  resp_data,
    output logic       resp_ack,
    output logic       idx_req,
    output csr_index_t idx_data,
    input  logic       idx_ack,
    output logic       busy
);

    logic        resp_push;
    logic        resp_pop;
    logic        resp_full;
    logic        resp_empty;
    csr_resp_t   resp_head;
    logic        cfg_push;
    logic        cfg_pop;
    logic        cfg_full;
    logic        cfg_empty;
    csr_config_t cfg_data;
    csr_config_t cfg_head;
    logic        gen_start;
    logic        gen_done;
    logic        conf_pending;

    csr_index_control csr_index_control_inst (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_req                   (resp_req),
        .resp_ack                   (resp_ack),
        .resp_full                  (resp_full),
        .resp_push                  (resp_push),
        .cfg_empty                  (cfg_empty),
        .cfg_pop                    (cfg_pop),
        .gen_start                  (gen_start),
        .gen_done                   (gen_done),
        .busy                       (busy),
        .conf_pending               (conf_pending)
    );

    // ----------------------------------------------------------
    // Response FIFO
    // ----------------------------------------------------------
    csr_sync_fifo #(
        .DATA_WIDTH ($bits(csr_resp_t)),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) resp_fifo_inst (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .push                       (resp_push),
        .push_data                  (resp_data),
        .pop                        (resp_pop),
        .pop_data                   (resp_head),
        .empty                      (resp_empty),
        .full                       (resp_full)
    );

    csr_index_configure #(
        .ID_ENGINE (ID_ENGINE)
    ) csr_index_configure_inst (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_empty                 (resp_empty),
        .resp_pop                   (resp_pop),
        .resp_head                  (resp_head),
        .cfg_full                   (cfg_full),
        .cfg_push                   (cfg_push),
        .cfg_data                   (cfg_data),
        .conf_pending               (conf_pending)
    );

    // ----------------------------------------------------------
    // Config FIFO
    // ----------------------------------------------------------
    csr_sync_fifo #(
        .DATA_WIDTH ($bits(csr_config_t)),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) cfg_fifo_inst (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .push                       (cfg_push),
        .push_data                  (cfg_data),
        .pop                        (cfg_pop),
        .pop_data                   (cfg_head),
        .empty                      (cfg_empty),
        .full                       (cfg_full)
    );

    csr_index_generator csr_index_generator_inst (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .gen_start                  (gen_start),
        .gen_cfg                    (cfg_head),
        .gen_done                   (gen_done),
        .idx_req                    (idx_req),
        .idx_data                   (idx_data),
        .idx_ack                    (idx_ack)
    );

endmodule : csr_index_top

// File: hw/csr_packet_pkg.sv
// ----------------------------------------------------------
// Packet formats for the lane: response packets, index
// configurations and emitted indices.
// ----------------------------------------------------------

package csr_packet_pkg;

    import csr_engine_pkg::*;

    // Routing tag carried by every packet, 10 bits
    typedef struct packed {
        logic [SUBCLASS_WIDTH-1:0] subclass;
        logic [ID_WIDTH-1:0]       cu_id;
        logic [ID_WIDTH-1:0]       engine_id;
    } csr_meta_t;

    // Memory response, 138 bits
    // field[0] index_start, field[1] index_end, field[3] array_size
    typedef struct packed {
        csr_meta_t                      meta;
        logic [3:0][INDEX_WIDTH-1:0]    field;
    } csr_resp_t;

    // Index range for one launch, end already clipped, 74 bits
    typedef struct packed {
        csr_meta_t              meta;
        logic [INDEX_WIDTH-1:0] index_start;
        logic [INDEX_WIDTH-1:0] index_end;
    } csr_config_t;

    // One emitted vertex index, 42 bits
    typedef struct packed {
        csr_meta_t              meta;
        logic [INDEX_WIDTH-1:0] index;
    } csr_index_t;

endpackage : csr_packet_pkg

// File: hw/csr_sync_fifo.sv
// ----------------------------------------------------------
// Synchronous first-word-fall-through FIFO. The head word is
// visible on pop_data whenever empty is low.
// ----------------------------------------------------------

`timescale 1ns/1ns

module csr_sync_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  ap_clk,
    input  logic                  areset_csr_index_generator,
    input  logic                  push,
    input  logic [DATA_WIDTH-1:0] push_data,
    input  logic                  pop,
    output logic [DATA_WIDTH-1:0] pop_data,
    output logic                  empty,
    output logic                  full
);

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

    // Extra top bit tells a full buffer from an empty one
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    // ----------------------------------------------------------
    // Pointers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr[ADDR_WIDTH-1:0]];
    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                      (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    // ----------------------------------------------------------
    // Checks on the users of this FIFO
    // ----------------------------------------------------------
    a_no_overflow : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        push |-> !full
    );

    a_no_underflow : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        pop |-> !empty
    );

endmodule : csr_sync_fifo

// File: sim/csr_index_checker.sv
// ----------------------------------------------------------
// Testbench checker. Acknowledges index transfers with random
// delays, models expected indices per accepted packet, counts errors.
// ----------------------------------------------------------

`timescale 1ns/1ns

module csr_index_checker
    import csr_engine_pkg::*;
    import csr_packet_pkg::*;
(
    input  logic       ap_clk,
    input  logic       resp_ack,
    input  csr_resp_t  resp_data,
    input  logic       pkt_kept,
    input  logic       idx_req,
    input  csr_index_t idx_data,
    output logic       idx_ack,
    input  logic       busy,
    input  logic [1:0] ack_delay,
    output logic       delay_used,
    output int         value_errors,
    output int         other_errors,
    output int         expected_total,
    output int         received
);

    localparam int WAIT_REQ = 0;
    localparam int DELAY    = 1;
    localparam int HOLD_ACK = 2;

    csr_index_t exp_q[$];
    csr_index_t held;
    logic       ack_seen;
    int         phase;
    int         wait_left;

    // Queue every index that a kept packet should produce
    task automatic expect_packet();
        logic [INDEX_WIDTH-1:0] stop;
        logic [INDEX_WIDTH-1:0] i;
        csr_index_t             item;
        // End is clipped to the array size
        stop = resp_data.field[1];
        if (stop > resp_data.field[3]) begin
            stop = resp_data.field[3];
        end
        if (pkt_kept) begin
            for (i = resp_data.field[0]; i < stop; i++) begin
                item.meta  = resp_data.meta;
                item.index = i;
                exp_q.push_back(item);
                expected_total++;
            end
        end
    endtask

    task automatic compare_index();
        csr_index_t want;
        received++;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("Index %0d arrived when no index was expected", idx_data.index);
        end else begin
            want = exp_q.pop_front();
            if (idx_data !== want) begin
                value_errors++;
                $display("FAIL idx_data got %h expected %h", idx_data, want);
            end
        end
    endtask

    // ----------------------------------------------------------
    // Ingress watch and egress handshake, one step per clock
    // ----------------------------------------------------------
    initial begin
        idx_ack        = 1'b0;
        delay_used     = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        expected_total = 0;
        received       = 0;
        ack_seen       = 1'b0;
        phase          = WAIT_REQ;
        wait_left      = 0;
        forever begin
            @(posedge ap_clk);
            #1;
            delay_used = 1'b0;
            // Packet data is held by the sender until ack
            if (resp_ack && !ack_seen) begin
                expect_packet();
            end
            ack_seen = resp_ack;
            case (phase)
                WAIT_REQ: begin
                    if (idx_req) begin
                        if (busy !== 1'b1) begin
                            other_errors++;
                            $display("busy was low while an index transfer was pending");
                        end
                        compare_index();
                        held       = idx_data;
                        delay_used = 1'b1;
                        if (ack_delay == 2'd0) begin
                            idx_ack = 1'b1;
                            phase   = HOLD_ACK;
                        end else begin
                            wait_left = ack_delay - 1;
                            phase     = DELAY;
                        end
                    end
                end
                DELAY: begin
                    if (!idx_req) begin
                        other_errors++;
                        $display("idx_req dropped before idx_ack was given");
                        phase = WAIT_REQ;
                    end else begin
                        if (idx_data !== held) begin
                            value_errors++;
                            $display("FAIL idx_data got %h while holding %h", idx_data, held);
                        end
                        if (wait_left == 0) begin
                            idx_ack = 1'b1;
                            phase   = HOLD_ACK;
                        end else begin
                            wait_left--;
                        end
                    end
                end
                default: begin
                    if (!idx_req) begin
                        idx_ack = 1'b0;
                        phase   = WAIT_REQ;
                    end
                end
            endcase
        end
    end

endmodule : csr_index_checker

// File: sim/csr_index_tb.sv
// ----------------------------------------------------------
// Testbench for the CSR index lane. Sends a table of response
// packets over the ingress handshake while the checker compares.
// ----------------------------------------------------------

`timescale 1ns/1ns

module csr_index_tb
    import csr_engine_pkg::*;
    import csr_packet_pkg::*;
();

    localparam int NUM_ROWS   = 22;
    localparam int MAX_RANGE  = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int ID_ENGINE  = 3;
    // Slowest index transfer takes five clocks
    localparam int WATCHDOG_NS = (NUM_ROWS * MAX_RANGE + 100) * 40;

    typedef struct packed {
        logic [SUBCLASS_WIDTH-1:0] subclass;
        logic [ID_WIDTH-1:0]       engine_id;
        logic [INDEX_WIDTH-1:0]    index_start;
        logic [INDEX_WIDTH-1:0]    index_end;
        logic [INDEX_WIDTH-1:0]    array_size;
        logic                      kept;
    } stim_row_t;

    logic        ap_clk = 1'b0;
    logic        areset_csr_index_generator;
    logic        resp_req;
    csr_resp_t   resp_data;
    logic        resp_ack;
    logic        idx_req;
    csr_index_t  idx_data;
    logic        idx_ack;
    logic        busy;
    logic        pkt_kept;
    logic [15:0] lfsr = 16'd7;
    logic [1:0]  ack_delay = 2'd1;
    logic        delay_used;
    int          value_errors;
    int          other_errors;
    int          expected_total;
    int          received;
    int          tb_errors;
    int          held_packets;
    stim_row_t   stim_table [NUM_ROWS];

    always #4 ap_clk = ~ap_clk;

    csr_index_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .ID_ENGINE  (ID_ENGINE)
    ) csr_index_top_inst (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_req                   (resp_req),
        .resp_data                  (resp_data),
        .resp_ack                   (resp_ack),
        .idx_req                    (idx_req),
        .idx_data                   (idx_data),
        .idx_ack                    (idx_ack),
        .busy                       (busy)
    );

    csr_index_checker csr_index_checker_inst (
        .ap_clk         (ap_clk),
        .resp_ack       (resp_ack),
        .resp_data      (resp_data),
        .pkt_kept       (pkt_kept),
        .idx_req        (idx_req),
        .idx_data       (idx_data),
        .idx_ack        (idx_ack),
        .busy           (busy),
        .ack_delay      (ack_delay),
        .delay_used     (delay_used),
        .value_errors   (value_errors),
        .other_errors   (other_errors),
        .expected_total (expected_total),
        .received       (received)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // New ack delay once the checker has used the last one
    always @(negedge ap_clk) begin
        if (delay_used) begin
            lfsr         = lfsr_next(lfsr);
            ack_delay[0] = lfsr[0];
            lfsr         = lfsr_next(lfsr);
            ack_delay[1] = lfsr[0];
        end
    end

    // ----------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------
    task automatic load_table();
        // Plain range, engine match, engine miss, bad subclasses
        stim_table[0]  = '{STRUCT_CU_SETUP,     4'd0, 32'd0,   32'd4,   32'd100,  1'b1};
        stim_table[1]  = '{STRUCT_ENGINE_SETUP, 4'd3, 32'd10,  32'd16,  32'd100,  1'b1};
        stim_table[2]  = '{STRUCT_ENGINE_SETUP, 4'd5, 32'd20,  32'd26,  32'd100,  1'b0};
        stim_table[3]  = '{2'd0,                4'd3, 32'd30,  32'd34,  32'd100,  1'b0};
        stim_table[4]  = '{2'd3,                4'd3, 32'd40,  32'd44,  32'd100,  1'b0};
        // Clipped end, empty range, start beyond clipped end
        stim_table[5]  = '{STRUCT_CU_SETUP,     4'd9, 32'd50,  32'd70,  32'd56,   1'b1};
        stim_table[6]  = '{STRUCT_CU_SETUP,     4'd0, 32'd60,  32'd60,  32'd100,  1'b1};
        stim_table[7]  = '{STRUCT_CU_SETUP,     4'd0, 32'd80,  32'd90,  32'd75,   1'b1};
        stim_table[8]  = '{STRUCT_ENGINE_SETUP, 4'd3, 32'd100, 32'd108, 32'd200,  1'b1};
        // Burst of long ranges to fill both FIFOs
        stim_table[9]  = '{STRUCT_CU_SETUP,     4'd0, 32'd200, 32'd208, 32'd1000, 1'b1};
        stim_table[10] = '{STRUCT_CU_SETUP,     4'd1, 32'd216, 32'd224, 32'd1000, 1'b1};
        stim_table[11] = '{STRUCT_CU_SETUP,     4'd2, 32'd232, 32'd240, 32'd1000, 1'b1};
        stim_table[12] = '{STRUCT_ENGINE_SETUP, 4'd3, 32'd248, 32'd256, 32'd1000, 1'b1};
        stim_table[13] = '{STRUCT_CU_SETUP,     4'd4, 32'd264, 32'd272, 32'd1000, 1'b1};
        stim_table[14] = '{STRUCT_CU_SETUP,     4'd5, 32'd280, 32'd288, 32'd1000, 1'b1};
        stim_table[15] = '{STRUCT_CU_SETUP,     4'd3, 32'd296, 32'd304, 32'd1000, 1'b1};
        stim_table[16] = '{STRUCT_CU_SETUP,     4'd7, 32'd312, 32'd320, 32'd1000, 1'b1};
        stim_table[17] = '{STRUCT_ENGINE_SETUP, 4'd3, 32'd328, 32'd336, 32'd1000, 1'b1};
        stim_table[18] = '{STRUCT_CU_SETUP,     4'd8, 32'd344, 32'd352, 32'd1000, 1'b1};
        stim_table[19] = '{STRUCT_CU_SETUP,     4'd9, 32'd360, 32'd368, 32'd1000, 1'b1};
        stim_table[20] = '{STRUCT_CU_SETUP,     4'd1, 32'd376, 32'd384, 32'd1000, 1'b1};
        stim_table[21] = '{STRUCT_CU_SETUP,     4'd2, 32'd392, 32'd400, 32'd1000, 1'b1};
    endtask

    task automatic next_drive_point();
        @(posedge ap_clk);
        #1;
    endtask

    // Four-phase ingress transfer of one table row
    task automatic send_packet(input int row);
        int waited;
        waited = 0;
        resp_data.meta.subclass  = stim_table[row].subclass;
        resp_data.meta.cu_id     = ID_WIDTH'(row);
        resp_data.meta.engine_id = stim_table[row].engine_id;
        resp_data.field[0]       = stim_table[row].index_start;
        resp_data.field[1]       = stim_table[row].index_end;
        resp_data.field[2]       = ~stim_table[row].index_start;
        resp_data.field[3]       = stim_table[row].array_size;
        pkt_kept                 = stim_table[row].kept;
        resp_req                 = 1'b1;
        next_drive_point();
        while (!resp_ack) begin
            waited++;
            next_drive_point();
        end
        resp_req = 1'b0;
        // Unblocked packets see ack on the second clock
        if (waited > 1) begin
            held_packets++;
        end
        while (resp_ack) begin
            next_drive_point();
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int row;
        int settled;
        areset_csr_index_generator = 1'b1;
        resp_req     = 1'b0;
        resp_data    = '0;
        pkt_kept     = 1'b0;
        tb_errors    = 0;
        held_packets = 0;
        load_table();
        repeat (2) @(posedge ap_clk);
        #1;
        areset_csr_index_generator = 1'b0;
        @(negedge ap_clk);
        if (busy !== 1'b0) begin
            tb_errors++;
            $display("busy is not low after reset");
        end
        next_drive_point();
        for (row = 0; row < NUM_ROWS; row++) begin
            send_packet(row);
        end
        // Wait for the lane to drain, watchdog bounds this
        @(negedge ap_clk);
        while (received != expected_total || busy !== 1'b0) begin
            @(negedge ap_clk);
        end
        settled = received;
        repeat (20) @(negedge ap_clk);
        if (received != settled || idx_req !== 1'b0 || busy !== 1'b0) begin
            tb_errors++;
            $display("Lane became active again after all indices were received");
        end
        if (held_packets == 0) begin
            tb_errors++;
            $display("resp_ack was never held off by a full response FIFO");
        end
        $display("Error counts: value %0d, protocol %0d, testbench %0d, indices %0d of %0d",
                 value_errors, other_errors, tb_errors, received, expected_total);
        if (value_errors + other_errors + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired with %0d of %0d indices received",
                 received, expected_total);
        $display("Error counts: value %0d, protocol %0d, testbench %0d",
                 value_errors, other_errors, tb_errors);
        $display("Errors found");
        $finish;
    end

endmodule : csr_index_tb
